// File: design/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // Data and address width of the core
  localparam int unsigned XLEN = 32;

  // Base opcode field, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_e;

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,
    S_EXEC,
    S_MEM,
    S_HALT
  } ctrl_state_e;

  typedef struct packed {
    alu_op_e         alu_op;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm;
    logic            use_imm;
    logic            reg_write;
    logic            is_load;
    logic            is_store;
    logic            is_branch;
    logic            branch_ne;
    logic            is_jal;
    logic            is_lui;
    logic            illegal;
  } decoded_t;

  // Master side of a request/grant/rvalid port
  typedef struct packed {
    logic            req;
    logic            we;
    logic [3:0]      be;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } bus_req_t;

  // Memory side of the same port
  typedef struct packed {
    logic            gnt;
    logic            rvalid;
    logic [XLEN-1:0] rdata;
  } bus_rsp_t;

endpackage

`default_nettype wire

// File: design/rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch import rv_pkg::*; (
  input  logic            clk_i,
  input  logic            arst_n_i,

  input  logic            fetch_start_i,
  input  logic [XLEN-1:0] pc_i,

  // Instruction bus
  output bus_req_t        bus_o,
  input  bus_rsp_t        bus_i,

  output logic            instr_valid_o,
  output logic [31:0]     instr_o
);

  logic            req_q;
  logic            wait_q;
  logic            valid_q;
  logic [XLEN-1:0] addr_q;
  logic [31:0]     instr_q;

  // Request, outstanding and valid flags
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_q   <= 1'b0;
      wait_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (fetch_start_i) begin
        req_q  <= 1'b1;
        wait_q <= 1'b0;
      end else if (req_q && bus_i.gnt) begin
        // Request accepted, now wait for the response
        req_q  <= 1'b0;
        wait_q <= 1'b1;
      end else if (wait_q && bus_i.rvalid) begin
        wait_q  <= 1'b0;
        valid_q <= 1'b1;
      end
    end
  end

  // Address and fetched word
  always_ff @(posedge clk_i) begin
    if (fetch_start_i) begin
      addr_q <= pc_i;
    end
    if (wait_q && bus_i.rvalid) begin
      instr_q <= bus_i.rdata;
    end
  end

  // Fetch is read only, full word
  assign bus_o = '{req: req_q, we: 1'b0, be: 4'b1111, addr: addr_q, wdata: '0};

  assign instr_valid_o = valid_q;
  assign instr_o       = instr_q;

endmodule

`default_nettype wire

// File: design/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder import rv_pkg::*; (
  input  logic [31:0] instr_i,
  output decoded_t    dec_o
);

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_u;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Sign extended immediates of each format
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};

  always_comb begin
    dec_o        = '0;
    dec_o.alu_op = ALU_ADD;
    dec_o.rs1    = instr_i[19:15];
    dec_o.rs2    = instr_i[24:20];
    dec_o.rd     = instr_i[11:7];

    case (opcode)
      OP_LUI: begin
        dec_o.imm       = imm_u;
        dec_o.is_lui    = 1'b1;
        dec_o.reg_write = 1'b1;
      end
      OP_IMM: begin
        dec_o.imm       = imm_i;
        dec_o.use_imm   = 1'b1;
        dec_o.reg_write = 1'b1;
        case (funct3)
          3'b000:  dec_o.alu_op = ALU_ADD;
          3'b100:  dec_o.alu_op = ALU_XOR;
          3'b110:  dec_o.alu_op = ALU_OR;
          3'b111:  dec_o.alu_op = ALU_AND;
          default: dec_o.illegal = 1'b1;
        endcase
      end
      OP_REG: begin
        dec_o.reg_write = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: dec_o.alu_op = ALU_ADD;
          {7'b0100000, 3'b000}: dec_o.alu_op = ALU_SUB;
          {7'b0000000, 3'b010}: dec_o.alu_op = ALU_SLT;
          {7'b0000000, 3'b100}: dec_o.alu_op = ALU_XOR;
          {7'b0000000, 3'b110}: dec_o.alu_op = ALU_OR;
          {7'b0000000, 3'b111}: dec_o.alu_op = ALU_AND;
          default:              dec_o.illegal = 1'b1;
        endcase
      end
      OP_LOAD: begin
        // Word access only
        dec_o.imm       = imm_i;
        dec_o.use_imm   = 1'b1;
        dec_o.is_load   = 1'b1;
        dec_o.reg_write = 1'b1;
        dec_o.illegal   = (funct3 != 3'b010);
      end
      OP_STORE: begin
        dec_o.imm      = imm_s;
        dec_o.use_imm  = 1'b1;
        dec_o.is_store = 1'b1;
        dec_o.illegal  = (funct3 != 3'b010);
      end
      OP_BRANCH: begin
        dec_o.imm       = imm_b;
        dec_o.is_branch = 1'b1;
        dec_o.branch_ne = funct3[0];
        // Only BEQ and BNE
        dec_o.illegal   = (funct3[2:1] != 2'b00);
      end
      OP_JAL: begin
        dec_o.imm       = imm_j;
        dec_o.is_jal    = 1'b1;
        dec_o.reg_write = 1'b1;
      end
      // ECALL and any other system instruction stop the core
      OP_SYSTEM: dec_o.illegal = 1'b1;
      default:   dec_o.illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: design/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  logic            clk_i,
  input  logic            arst_n_i,

  input  logic [4:0]      raddr_a_i,
  input  logic [4:0]      raddr_b_i,
  input  logic [4:0]      waddr_i,
  input  logic            we_i,
  input  logic [XLEN-1:0] wdata_i,

  output logic [XLEN-1:0] rdata_a_o,
  output logic [XLEN-1:0] rdata_b_o
);

  // x1 to x31, x0 has no storage
  logic [XLEN-1:0] regs_q [1:31];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != 5'd0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == 5'd0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == 5'd0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

// File: design/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu import rv_pkg::*; (
  input  alu_op_e         op_i,
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  output logic [XLEN-1:0] result_o,
  output logic            equal_o
);

  logic less_signed;

  assign less_signed = $signed(a_i) < $signed(b_i);

  always_comb begin
    case (op_i)
      ALU_ADD: result_o = a_i + b_i;
      ALU_SUB: result_o = a_i - b_i;
      ALU_AND: result_o = a_i & b_i;
      ALU_OR:  result_o = a_i | b_i;
      ALU_XOR: result_o = a_i ^ b_i;
      ALU_SLT: result_o = {{(XLEN-1){1'b0}}, less_signed};
      default: result_o = '0;
    endcase
  end

  // Branch compare, independent of op_i
  assign equal_o = (a_i == b_i);

endmodule

`default_nettype wire

// File: design/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            fetch_enable_i,
  input  logic [XLEN-1:0] boot_addr_i,

  output bus_req_t        instr_req_o,
  input  bus_rsp_t        instr_rsp_i,

  output bus_req_t        data_req_o,
  input  bus_rsp_t        data_rsp_i,

  output logic            core_sleep_o
);

  ctrl_state_e     state_q;
  ctrl_state_e     state_d;
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] pc_next;
  logic [XLEN-1:0] fetch_pc;
  logic            fetch_start;
  logic            instr_valid;
  logic [31:0]     instr;
  decoded_t        dec;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_result;
  logic            alu_equal;
  logic            branch_taken;
  logic            is_mem;
  logic            mem_start;
  logic            rf_we;
  logic [XLEN-1:0] rf_wdata;
  logic            data_req_q;
  logic            data_we_q;
  logic [XLEN-1:0] data_addr_q;
  logic [XLEN-1:0] data_wdata_q;

  rv_fetch u_fetch (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .fetch_start_i (fetch_start),
    .pc_i          (fetch_pc),
    .bus_o         (instr_req_o),
    .bus_i         (instr_rsp_i),
    .instr_valid_o (instr_valid),
    .instr_o       (instr)
  );

  rv_decoder u_decoder (
    .instr_i (instr),
    .dec_o   (dec)
  );

  rv_regfile u_regfile (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .raddr_a_i (dec.rs1),
    .raddr_b_i (dec.rs2),
    .waddr_i   (dec.rd),
    .we_i      (rf_we),
    .wdata_i   (rf_wdata),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data)
  );

  assign alu_b = dec.use_imm ? dec.imm : rs2_data;

  rv_alu u_alu (
    .op_i     (dec.alu_op),
    .a_i      (rs1_data),
    .b_i      (alu_b),
    .result_o (alu_result),
    .equal_o  (alu_equal)
  );

  // Next PC selection
  assign pc_plus4     = pc_q + 32'd4;
  assign branch_taken = dec.is_branch && (alu_equal ^ dec.branch_ne);
  assign pc_next      = (dec.is_jal || branch_taken) ? pc_q + dec.imm : pc_plus4;
  assign fetch_pc     = (state_q == S_IDLE) ? boot_addr_i : pc_next;
  assign is_mem       = dec.is_load || dec.is_store;

  // Register write data
  always_comb begin
    if (dec.is_load) begin
      rf_wdata = data_rsp_i.rdata;
    end else if (dec.is_jal) begin
      rf_wdata = pc_plus4;
    end else if (dec.is_lui) begin
      rf_wdata = dec.imm;
    end else begin
      rf_wdata = alu_result;
    end
  end

  // Controller
  always_comb begin
    state_d     = state_q;
    fetch_start = 1'b0;
    mem_start   = 1'b0;
    rf_we       = 1'b0;
    case (state_q)
      S_IDLE: begin
        if (fetch_enable_i) begin
          fetch_start = 1'b1;
          state_d     = S_FETCH;
        end
      end
      S_FETCH: begin
        if (instr_valid) begin
          state_d = S_EXEC;
        end
      end
      S_EXEC: begin
        if (dec.illegal) begin
          state_d = S_HALT;
        end else if (is_mem) begin
          mem_start = 1'b1;
          state_d   = S_MEM;
        end else begin
          // Retire and fetch the next instruction
          rf_we       = dec.reg_write;
          fetch_start = 1'b1;
          state_d     = S_FETCH;
        end
      end
      S_MEM: begin
        // Response only counts once the request has been granted
        if (!data_req_q && data_rsp_i.rvalid) begin
          rf_we       = dec.is_load;
          fetch_start = 1'b1;
          state_d     = S_FETCH;
        end
      end
      S_HALT:  state_d = S_HALT;
      default: state_d = S_HALT;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= S_IDLE;
      pc_q       <= '0;
      data_req_q <= 1'b0;
      data_we_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (fetch_start) begin
        pc_q <= fetch_pc;
      end
      if (mem_start) begin
        data_req_q <= 1'b1;
        data_we_q  <= dec.is_store;
      end else if (data_req_q && data_rsp_i.gnt) begin
        data_req_q <= 1'b0;
      end
    end
  end

  // Load/store address and store data, rs1 plus imm
  always_ff @(posedge clk_i) begin
    if (mem_start) begin
      data_addr_q  <= alu_result;
      data_wdata_q <= rs2_data;
    end
  end

  assign data_req_o = '{req:   data_req_q,
                        we:    data_we_q,
                        be:    4'b1111,
                        addr:  data_addr_q,
                        wdata: data_wdata_q};

  assign core_sleep_o = (state_q == S_HALT);

endmodule

`default_nettype wire

// File: design/rv_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

module rv_wrapper import rv_pkg::*; (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            fetch_enable_i,
  input  logic [XLEN-1:0] boot_addr_i,

  // Instruction memory port
  output logic            instr_req_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  output logic [XLEN-1:0] instr_addr_o,
  input  logic [XLEN-1:0] instr_rdata_i,

  // Data memory port
  output logic            data_req_o,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  output logic            data_we_o,
  output logic [3:0]      data_be_o,
  output logic [XLEN-1:0] data_addr_o,
  output logic [XLEN-1:0] data_wdata_o,
  input  logic [XLEN-1:0] data_rdata_i,

  output logic            core_sleep_o
);

  bus_req_t instr_req;
  bus_rsp_t instr_rsp;
  bus_req_t data_req;
  bus_rsp_t data_rsp;

  assign instr_rsp = '{gnt: instr_gnt_i, rvalid: instr_rvalid_i, rdata: instr_rdata_i};
  assign data_rsp  = '{gnt: data_gnt_i, rvalid: data_rvalid_i, rdata: data_rdata_i};

  // Fetch never writes, so only req and addr leave the instruction port
  assign instr_req_o  = instr_req.req;
  assign instr_addr_o = instr_req.addr;

  assign data_req_o   = data_req.req;
  assign data_we_o    = data_req.we;
  assign data_be_o    = data_req.be;
  assign data_addr_o  = data_req.addr;
  assign data_wdata_o = data_req.wdata;

  rv_core u_core (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .fetch_enable_i (fetch_enable_i),
    .boot_addr_i    (boot_addr_i),
    .instr_req_o    (instr_req),
    .instr_rsp_i    (instr_rsp),
    .data_req_o     (data_req),
    .data_rsp_i     (data_rsp),
    .core_sleep_o   (core_sleep_o)
  );

endmodule

`default_nettype wire

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset released just after a rising edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: tests/rv_bus_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module rv_bus_assertions (
  input logic        clk_i,
  input logic        arst_n_i,
  input logic        instr_req_o,
  input logic        instr_gnt_i,
  input logic        instr_rvalid_i,
  input logic [31:0] instr_addr_o,
  input logic        data_req_o,
  input logic        data_gnt_i,
  input logic        data_rvalid_i,
  input logic        data_we_o,
  input logic [3:0]  data_be_o,
  input logic [31:0] data_addr_o,
  input logic [31:0] data_wdata_o,
  input logic        core_sleep_o
);

  logic instr_pend_q;
  logic data_pend_q;

  // Granted but not yet answered
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      instr_pend_q <= 1'b0;
      data_pend_q  <= 1'b0;
    end else begin
      if (instr_req_o && instr_gnt_i) begin
        instr_pend_q <= 1'b1;
      end else if (instr_rvalid_i) begin
        instr_pend_q <= 1'b0;
      end
      if (data_req_o && data_gnt_i) begin
        data_pend_q <= 1'b1;
      end else if (data_rvalid_i) begin
        data_pend_q <= 1'b0;
      end
    end
  end

  a_instr_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("Instruction request changed before its grant");

  a_data_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    data_req_o && !data_gnt_i |=>
      data_req_o && $stable({data_we_o, data_be_o, data_addr_o, data_wdata_o}))
    else $error("Data request changed before its grant");

  a_instr_one_outstanding: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    instr_pend_q |-> !instr_req_o)
    else $error("New instruction request before the previous response");

  a_data_one_outstanding: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    data_pend_q |-> !data_req_o)
    else $error("New data request before the previous response");

  a_instr_rvalid_granted: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    instr_rvalid_i |-> instr_pend_q)
    else $error("Instruction rvalid without a granted request");

  a_data_rvalid_granted: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    data_rvalid_i |-> data_pend_q)
    else $error("Data rvalid without a granted request");

  a_quiet_in_sleep: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    core_sleep_o |-> !instr_req_o && !data_req_o)
    else $error("Bus request while the core sleeps");

endmodule

bind rv_wrapper rv_bus_assertions u_bus_assertions (
  .clk_i          (clk_i),
  .arst_n_i       (arst_n_i),
  .instr_req_o    (instr_req_o),
  .instr_gnt_i    (instr_gnt_i),
  .instr_rvalid_i (instr_rvalid_i),
  .instr_addr_o   (instr_addr_o),
  .data_req_o     (data_req_o),
  .data_gnt_i     (data_gnt_i),
  .data_rvalid_i  (data_rvalid_i),
  .data_we_o      (data_we_o),
  .data_be_o      (data_be_o),
  .data_addr_o    (data_addr_o),
  .data_wdata_o   (data_wdata_o),
  .core_sleep_o   (core_sleep_o)
);

`default_nettype wire

// File: tests/tb_rv_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_wrapper;

  localparam int          CLK_PERIOD_NS = 8;
  localparam int          RESET_CYCLES  = 16;
  localparam int          PROG_LEN      = 34;
  localparam int          IDLE_CYCLES   = 10;
  localparam int          HALT_CYCLES   = 50;
  localparam int          TIMEOUT_NS    = PROG_LEN * 40 * CLK_PERIOD_NS;
  localparam logic [31:0] BOOT_ADDR     = 32'h0000_1000;
  localparam logic [31:0] DATA_BASE     = 32'h0000_2000;

  // One program word, with the store it should produce
  typedef struct packed {
    logic [31:0] instr;
    logic        is_store;
    logic [31:0] addr;
    logic [31:0] data;
  } prog_entry_t;

  logic        clk;
  logic        arst_n;
  logic        fetch_enable;
  logic [31:0] boot_addr;
  logic        instr_req;
  logic        instr_gnt;
  logic        instr_rvalid;
  logic [31:0] instr_addr;
  logic [31:0] instr_rdata;
  logic        data_req;
  logic        data_gnt;
  logic        data_rvalid;
  logic        data_we;
  logic [3:0]  data_be;
  logic [31:0] data_addr;
  logic [31:0] data_wdata;
  logic [31:0] data_rdata;
  logic        core_sleep;

  prog_entry_t prog [PROG_LEN];
  prog_entry_t exp_q [$];
  logic [31:0] imem [logic [31:0]];
  logic [31:0] dmem [logic [31:0]];
  int          prog_n;
  int          exp_count;
  int          store_count;
  logic        first_fetch;
  integer      seed = 32'h2562;

  tb_clock_gen #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clock_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  rv_wrapper u_rv_wrapper (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .fetch_enable_i (fetch_enable),
    .boot_addr_i    (boot_addr),
    .instr_req_o    (instr_req),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .instr_addr_o   (instr_addr),
    .instr_rdata_i  (instr_rdata),
    .data_req_o     (data_req),
    .data_gnt_i     (data_gnt),
    .data_rvalid_i  (data_rvalid),
    .data_we_o      (data_we),
    .data_be_o      (data_be),
    .data_addr_o    (data_addr),
    .data_wdata_o   (data_wdata),
    .data_rdata_i   (data_rdata),
    .core_sleep_o   (core_sleep)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
    end
  endtask

  // RV32I instruction encodings
  function automatic logic [31:0] sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] itype_word(input logic [6:0] op, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                             input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic add_op(input logic [31:0] word);
    if (prog_n >= PROG_LEN) begin
      abort_run("Program table overflow");
    end else begin
      prog[prog_n] = '{instr: word, is_store: 1'b0, addr: 32'd0, data: 32'd0};
      prog_n++;
    end
  endtask

  task automatic add_store(input logic [31:0] word, input logic [31:0] addr,
                           input logic [31:0] data);
    if (prog_n >= PROG_LEN) begin
      abort_run("Program table overflow");
    end else begin
      prog[prog_n] = '{instr: word, is_store: 1'b1, addr: addr, data: data};
      prog_n++;
    end
  endtask

  // Instruction memory, random grant and response delays
  initial begin : instr_memory
    int unsigned wait_cycles;
    logic [31:0] addr;
    instr_gnt    = 1'b0;
    instr_rvalid = 1'b0;
    instr_rdata  = 32'd0;
    forever begin
      @(posedge clk);
      #1;
      if (instr_req) begin
        wait_cycles = $unsigned($random(seed)) % 4;
        repeat (wait_cycles) begin
          @(posedge clk);
          #1;
        end
        addr = instr_addr;
        if (first_fetch) begin
          check_value("instr_addr_o", addr, BOOT_ADDR);
          first_fetch = 1'b0;
        end
        instr_gnt = 1'b1;
        @(posedge clk);
        #1;
        instr_gnt   = 1'b0;
        wait_cycles = $unsigned($random(seed)) % 2;
        repeat (wait_cycles) begin
          @(posedge clk);
          #1;
        end
        if (imem.exists(addr)) begin
          instr_rdata  = imem[addr];
          instr_rvalid = 1'b1;
          @(posedge clk);
          #1;
          instr_rvalid = 1'b0;
        end else begin
          abort_run("Instruction fetch from outside the program");
        end
      end
    end
  end

  // Data memory, checks each store against the expected list
  initial begin : data_memory
    int unsigned wait_cycles;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        we;
    prog_entry_t exp_store;
    data_gnt    = 1'b0;
    data_rvalid = 1'b0;
    data_rdata  = 32'd0;
    forever begin
      @(posedge clk);
      #1;
      if (data_req) begin
        wait_cycles = $unsigned($random(seed)) % 4;
        repeat (wait_cycles) begin
          @(posedge clk);
          #1;
        end
        addr  = data_addr;
        wdata = data_wdata;
        we    = data_we;
        check_value("data_be_o", 32'(data_be), 32'h0000_000f);
        data_gnt = 1'b1;
        @(posedge clk);
        #1;
        data_gnt    = 1'b0;
        wait_cycles = $unsigned($random(seed)) % 2;
        repeat (wait_cycles) begin
          @(posedge clk);
          #1;
        end
        if (we && exp_q.size() == 0) begin
          abort_run("The core made a store after the last expected store");
        end else if (!we && !dmem.exists(addr)) begin
          abort_run("The core loaded from an address that was never written");
        end else begin
          if (we) begin
            exp_store = exp_q.pop_front();
            check_value("data_addr_o", addr, exp_store.addr);
            check_value("data_wdata_o", wdata, exp_store.data);
            dmem[addr] = wdata;
            store_count++;
          end else begin
            data_rdata = dmem[addr];
          end
          data_rvalid = 1'b1;
          @(posedge clk);
          #1;
          data_rvalid = 1'b0;
        end
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    abort_run("Timeout: the core did not halt within the time limit");
  end

  initial begin : main
    logic [31:0] x1, x2, x3, x4, x5, x6, x7;
    logic [31:0] x8, x9, x11, x12, x13, x15;
    fetch_enable = 1'b0;
    boot_addr    = BOOT_ADDR;
    prog_n       = 0;
    store_count  = 0;
    first_fetch  = 1'b1;

    // Register values by the RV32I rules, x10 holds DATA_BASE
    x1  = {20'h12345, 12'h000} + sext12(12'h678);
    x2  = 32'd0 + sext12(12'hffb);
    x3  = x1 & sext12(12'h0f0);
    x4  = x3 | sext12(12'hf00);
    x5  = x4 ^ sext12(12'h555);
    x6  = x1 + x2;
    x7  = x2 - x1;
    x8  = x1 & x4;
    x9  = x3 | x2;
    x11 = x1 ^ x5;
    x12 = ($signed(x2) < $signed(x1)) ? 32'd1 : 32'd0;
    x13 = ($signed(x1) < $signed(x2)) ? 32'd1 : 32'd0;
    // Link of the JAL at word 30
    x15 = BOOT_ADDR + 32'd4 * 32'd30 + 32'd4;

    add_op(lui_word(5'd10, 20'h00002));
    add_op(lui_word(5'd1, 20'h12345));
    add_op(itype_word(7'b0010011, 3'b000, 5'd1, 5'd1, 12'h678));
    add_store(store_word(5'd1, 5'd10, 12'd0), DATA_BASE, x1);
    add_op(itype_word(7'b0010011, 3'b000, 5'd2, 5'd0, 12'hffb));
    add_op(itype_word(7'b0010011, 3'b111, 5'd3, 5'd1, 12'h0f0));
    add_op(itype_word(7'b0010011, 3'b110, 5'd4, 5'd3, 12'hf00));
    add_op(itype_word(7'b0010011, 3'b100, 5'd5, 5'd4, 12'h555));
    add_store(store_word(5'd2, 5'd10, 12'd4), DATA_BASE + 32'd4, x2);
    add_store(store_word(5'd5, 5'd10, 12'd8), DATA_BASE + 32'd8, x5);
    add_op(rtype_word(7'b0000000, 3'b000, 5'd6, 5'd1, 5'd2));
    add_op(rtype_word(7'b0100000, 3'b000, 5'd7, 5'd2, 5'd1));
    add_op(rtype_word(7'b0000000, 3'b111, 5'd8, 5'd1, 5'd4));
    add_op(rtype_word(7'b0000000, 3'b110, 5'd9, 5'd3, 5'd2));
    add_op(rtype_word(7'b0000000, 3'b100, 5'd11, 5'd1, 5'd5));
    add_op(rtype_word(7'b0000000, 3'b010, 5'd12, 5'd2, 5'd1));
    add_op(rtype_word(7'b0000000, 3'b010, 5'd13, 5'd1, 5'd2));
    add_store(store_word(5'd6, 5'd10, 12'd12), DATA_BASE + 32'd12, x6);
    add_store(store_word(5'd7, 5'd10, 12'd16), DATA_BASE + 32'd16, x7);
    add_store(store_word(5'd8, 5'd10, 12'd20), DATA_BASE + 32'd20, x8);
    add_store(store_word(5'd9, 5'd10, 12'd24), DATA_BASE + 32'd24, x9);
    add_store(store_word(5'd11, 5'd10, 12'd28), DATA_BASE + 32'd28, x11);
    add_store(store_word(5'd12, 5'd10, 12'd32), DATA_BASE + 32'd32, x12);
    add_store(store_word(5'd13, 5'd10, 12'd36), DATA_BASE + 32'd36, x13);
    // Load back the first word and store it again
    add_op(itype_word(7'b0000011, 3'b010, 5'd14, 5'd10, 12'd0));
    add_store(store_word(5'd14, 5'd10, 12'd64), DATA_BASE + 32'd64, x1);
    // Taken BEQ skips the marker store
    add_op(branch_word(3'b000, 5'd3, 5'd3, 13'd8));
    add_op(store_word(5'd1, 5'd10, 12'd100));
    // BNE on equal operands falls through
    add_op(branch_word(3'b001, 5'd12, 5'd12, 13'd8));
    add_store(store_word(5'd12, 5'd10, 12'd68), DATA_BASE + 32'd68, x12);
    add_op(jal_word(5'd15, 21'd8));
    add_op(store_word(5'd2, 5'd10, 12'd104));
    add_store(store_word(5'd15, 5'd10, 12'd72), DATA_BASE + 32'd72, x15);
    // ECALL
    add_op(32'h0000_0073);
    check_value("program length", 32'(prog_n), 32'(PROG_LEN));

    for (int i = 0; i < PROG_LEN; i++) begin
      imem[BOOT_ADDR + 32'(4 * i)] = prog[i].instr;
      if (prog[i].is_store) begin
        exp_q.push_back(prog[i]);
      end
    end
    exp_count = exp_q.size();

    @(posedge arst_n);
    // Core must stay quiet until enabled
    repeat (IDLE_CYCLES) begin
      @(posedge clk);
      #1;
      check_value("instr_req_o", 32'(instr_req), 32'd0);
      check_value("data_req_o", 32'(data_req), 32'd0);
      check_value("core_sleep_o", 32'(core_sleep), 32'd0);
    end
    fetch_enable = 1'b1;

    while (!core_sleep) begin
      @(posedge clk);
      #1;
    end

    repeat (HALT_CYCLES) begin
      @(posedge clk);
      #1;
      check_value("instr_req_o", 32'(instr_req), 32'd0);
      check_value("data_req_o", 32'(data_req), 32'd0);
      check_value("core_sleep_o", 32'(core_sleep), 32'd1);
    end
    check_value("store count", 32'(store_count), 32'(exp_count));

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
design/rv_pkg.sv
design/rv_fetch.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_core.sv
design/rv_wrapper.sv
tests/tb_clock_gen.sv
tests/rv_bus_assertions.sv
tests/tb_rv_wrapper.sv

// File: run.sh
#!/bin/sh
# Build and run the rv_wrapper testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project directory"
  exit 1
fi

TOP=tb_rv_wrapper
LOG=sim.log

verilator --binary --assert --top-module "$TOP" -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
if ! grep -q "TESTBENCH PASSED" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi

echo "Simulation passed"
exit 0
